// ==== cart_map.f ====
+incdir+rtl
rtl/cart_map_pkg.sv
rtl/lhrom_map.sv
rtl/sdd1_map.sv
rtl/map_select.sv
rtl/cpu_read_mux.sv
rtl/cart_map.sv
dv/cart_map_checker.sv
dv/cart_map_tb.sv

// ==== Makefile ====
# Verilator build and run for the cartridge mapper testbench

TOP       ?= cart_map_tb
SEED      ?= 32'hf7c2ff8e
LOG       ?= sim.log
FLIST     ?= cart_map.f
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard rtl/*.sv rtl/*.svh dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) "-GSEED=$(SEED)" -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG) || ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/cart_map_tb.sv ====
// cartridge mapper testbench
`timescale 1ns/1ns
`include "cart_map_config.svh"

module cart_map_tb #(
	parameter logic [31:0] SEED = 32'hf7c2ff8e
);

	localparam int N_READ = 40;
	localparam int N_WRITE = 16;
	// reset idles, reads, BSRAM writes with readback, bank register traffic
	localparam int TXN_TOTAL = 4 + 4 * N_READ + N_READ / 2 + 6 * N_WRITE;

	logic                     mclk;
	logic                     rst_n;
	logic [`CART_ADDR_W-1:0]  ca;
	logic [7:0]               cpu_di;
	logic                     cpurd_n;
	logic                     cpuwr_n;
	logic                     sysclkf_ce;
	logic                     sysclkr_ce;
	logic [7:0]               map_ctrl;
	logic [`ROM_ADDR_W-1:0]   rom_mask;
	logic [`BSRAM_ADDR_W-1:0] ram_mask;
	logic [15:0]              rom_q;
	logic [7:0]               bsram_q;
	logic [`ROM_ADDR_W-1:0]   rom_addr;
	logic                     rom_ce_n;
	logic                     rom_oe_n;
	logic [`BSRAM_ADDR_W-1:0] bsram_addr;
	logic [7:0]               bsram_d;
	logic                     bsram_ce_n;
	logic                     bsram_oe_n;
	logic                     bsram_we_n;
	logic [7:0]               cart_do;
	int                       test_id;
	logic                     test_done;
	int                       errors;
	int                       checks;
	logic                     timed_out;
	logic [31:0]              rng;
	logic [7:0]               bsram_mem [1 << `BSRAM_ADDR_W];
	logic [23:0]              written [N_WRITE];

	cart_map uut (.*);

	cart_map_checker #(.TXN_TOTAL(TXN_TOTAL)) u_checker (.*);

	initial begin
		mclk = 1'b0;
		forever #4 mclk = ~mclk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic roll(output logic [31:0] r);
		rng = xorshift(rng);
		r = rng;
	endtask

	function automatic logic [7:0] rom_byte_of(input logic [23:0] a);
		return a[7:0] ^ {a[12:8], a[15:13]} ^ a[23:16] ^ 8'h96;
	endfunction

	// 16-bit ROM with the even byte low
	assign rom_q = {rom_byte_of({rom_addr[23:1], 1'b1}), rom_byte_of({rom_addr[23:1], 1'b0})};
	assign bsram_q = bsram_mem[bsram_addr];

	always @(posedge mclk) begin
		if (!bsram_ce_n && !bsram_we_n)
			bsram_mem[bsram_addr] = bsram_d;
	end

	// upper half offset keeps clear of LoROM BSRAM and 7E/7F move up to FE/FF
	function automatic logic [23:0] rom_area_addr(input logic [31:0] r);
		logic [23:0] a;
		a = r[23:0];
		a[15] = 1'b1;
		if (a[23:17] == 7'h3f)
			a[23] = 1'b1;
		return a;
	endfunction

	task automatic bus_cycle(input logic rd, input logic wr, input logic [23:0] addr,
		input logic [7:0] data);
		@(posedge mclk);
		#1;
		ca = addr;
		cpu_di = data;
		cpurd_n = !rd;
		cpuwr_n = !wr;
	endtask

	task automatic end_test;
		bus_cycle(1'b0, 1'b0, ca, 8'h00);
		bus_cycle(1'b0, 1'b0, ca, 8'h00);
		@(posedge mclk);
		#1;
		test_done = 1'b1;
		@(posedge mclk);
		#1;
		test_done = 1'b0;
		test_id = test_id + 1;
	endtask

	always @(posedge mclk) begin
		if (timed_out) begin
			$display("CHECKS FAILED");
			$finish;
		end
	end

	initial begin
		logic [31:0] r;
		logic [23:0] a;
		logic [15:0] off;
		rng = SEED;
		rst_n = 1'b0;
		ca = '0;
		cpu_di = 8'h00;
		cpurd_n = 1'b1;
		cpuwr_n = 1'b1;
		sysclkf_ce = 1'b1;
		sysclkr_ce = 1'b1;
		map_ctrl = 8'h00;
		rom_mask = '1;
		ram_mask = '1;
		test_id = 1;
		test_done = 1'b0;
		for (int i = 0; i < (1 << `BSRAM_ADDR_W); i++)
			bsram_mem[i] = i[7:0] ^ i[15:8] ^ {i[19:16], 4'h9};
		repeat (4) @(posedge mclk);
		#1;
		rst_n = 1'b1;
		repeat (4) bus_cycle(1'b0, 1'b0, '0, 8'h00);
		end_test;
		// LoROM reads
		roll(r);
		rom_mask = r[23:0];
		for (int i = 0; i < N_READ; i++) begin
			roll(r);
			bus_cycle(1'b1, 1'b0, rom_area_addr(r), 8'h00);
		end
		end_test;
		// HiROM reads then holes that nothing answers
		map_ctrl = 8'h01;
		for (int i = 0; i < N_READ; i++) begin
			roll(r);
			bus_cycle(1'b1, 1'b0, rom_area_addr(r), 8'h00);
		end
		for (int i = 0; i < N_READ / 2; i++) begin
			roll(r);
			off = r[15:0] % 16'h6000;
			bus_cycle(1'b1, 1'b0, {r[23], 1'b0, r[21:16], off}, 8'h00);
		end
		end_test;
		// BSRAM writes then readback in the LoROM and HiROM windows
		for (int m = 0; m < 2; m++) begin
			map_ctrl = {7'h00, m[0]};
			roll(r);
			ram_mask = r[19:0];
			for (int i = 0; i < N_WRITE; i++) begin
				roll(r);
				if (m == 0)
					written[i] = {4'h7, r[19:16] % 4'd14, 1'b0, r[14:0]};
				else
					written[i] = {r[23], 2'b01, r[20:16], 3'b011, r[12:0]};
				bus_cycle(1'b0, 1'b1, written[i], r[31:24]);
			end
			for (int i = 0; i < N_WRITE; i++)
				bus_cycle(1'b1, 1'b0, written[i], 8'h00);
			// last read registers before the mode and mask move
			bus_cycle(1'b0, 1'b0, '0, 8'h00);
		end
		end_test;
		// S-DD1 bank registers and the C0-FF windows
		map_ctrl = 8'h50;
		rom_mask = '1;
		for (int i = 0; i < N_WRITE; i++) begin
			roll(r);
			a = {r[23], 1'b0, r[21:16], 14'h1201, r[1:0]};
			bus_cycle(1'b0, 1'b1, a, r[31:24]);
			bus_cycle(1'b1, 1'b0, a, 8'h00);
		end
		for (int i = 0; i < N_READ; i++) begin
			roll(r);
			bus_cycle(1'b1, 1'b0, {2'b11, r[21:0]}, 8'h00);
		end
		end_test;
		// system banks keep LoROM with S-DD1 active
		roll(r);
		rom_mask = r[23:0];
		for (int i = 0; i < N_READ; i++) begin
			roll(r);
			a = rom_area_addr(r);
			if (a[23:22] == 2'b11)
				a[22] = 1'b0;
			bus_cycle(1'b1, 1'b0, a, 8'h00);
		end
		end_test;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== dv/cart_map_checker.sv ====
// cartridge mapper reference checker
`timescale 1ns/1ns
`include "cart_map_config.svh"

module cart_map_checker #(
	parameter int TXN_TOTAL = 0
) (
	input  logic                     mclk,
	input  logic                     rst_n,
	input  logic [`CART_ADDR_W-1:0]  ca,
	input  logic [7:0]               cpu_di,
	input  logic                     cpurd_n,
	input  logic                     cpuwr_n,
	input  logic                     sysclkf_ce,
	input  logic [7:0]               map_ctrl,
	input  logic [`ROM_ADDR_W-1:0]   rom_mask,
	input  logic [`BSRAM_ADDR_W-1:0] ram_mask,
	input  logic [`ROM_ADDR_W-1:0]   rom_addr,
	input  logic                     rom_ce_n,
	input  logic                     rom_oe_n,
	input  logic [`BSRAM_ADDR_W-1:0] bsram_addr,
	input  logic [7:0]               bsram_d,
	input  logic                     bsram_ce_n,
	input  logic                     bsram_oe_n,
	input  logic                     bsram_we_n,
	input  logic [7:0]               cart_do,
	input  int                       test_id,
	input  logic                     test_done,
	output int                       errors,
	output int                       checks,
	output logic                     timed_out
);

	localparam int LIMIT = 4 * TXN_TOTAL + 100;

	logic [3:0]  bank_model [4];
	logic [7:0]  bsram_shadow [logic [19:0]];
	logic        pend = 1'b0;
	logic [23:0] e_rom_addr;
	logic        e_rom_ce_n;
	logic        e_rom_oe_n;
	logic [19:0] e_bsram_addr;
	logic [7:0]  e_bsram_d;
	logic        e_bsram_ce_n;
	logic        e_bsram_oe_n;
	logic        e_bsram_we_n;
	logic [7:0]  e_cart_do;
	logic        e_do_known;
	int          cycles = 0;
	int          err_total = 0;
	int          check_total = 0;
	int          test_errors = 0;
	int          test_checks = 0;

	assign errors = err_total;
	assign checks = check_total;
	assign timed_out = cycles > LIMIT;

	function automatic string test_name(input int id);
		case (id)
			1: return "reset";
			2: return "lorom_read";
			3: return "hirom_read";
			4: return "bsram_write";
			5: return "sdd1_banks";
			6: return "sdd1_lorom";
			default: return "unknown";
		endcase
	endfunction

	function automatic logic [7:0] rom_byte_of(input logic [23:0] a);
		return a[7:0] ^ {a[12:8], a[15:13]} ^ a[23:16] ^ 8'h96;
	endfunction

	task automatic compare(input string field, input logic [23:0] exp_val,
		input logic [23:0] act_val);
		check_total++;
		test_checks++;
		if (act_val !== exp_val) begin
			err_total++;
			test_errors++;
			$display("mismatch %s %s: expected %h actual %h",
				test_name(test_id), field, exp_val, act_val);
		end
	endtask

	// predict what the DUT registers on this edge
	always @(posedge mclk) begin
		logic [7:0]  bank;
		logic [15:0] off;
		logic        rd;
		logic        wr;
		logic        active;
		logic        hirom;
		logic        reg_sel;
		logic        rom_area;
		logic        ram_hit;
		logic [23:0] raddr;
		logic [19:0] baddr;
		bank = ca[23:16];
		off = ca[15:0];
		rd = !cpurd_n && rst_n;
		wr = !cpuwr_n && rst_n;
		active = map_ctrl[7:4] == 4'h5;
		hirom = map_ctrl[0] && !active;
		reg_sel = active && !bank[6] && off >= 16'h4804 && off <= 16'h4807;
		rom_area = (bank >= 8'h40 && bank <= 8'h7d) || bank >= 8'hc0 || (!bank[6] && off[15]);
		if (hirom) begin
			ram_hit = bank[6:5] == 2'b01 && off >= 16'h6000 && off < 16'h8000;
			raddr = {2'b00, ca[21:0]};
			baddr = {2'b00, bank[4:0], off[12:0]};
		end else begin
			ram_hit = bank >= 8'h70 && bank <= 8'h7d && !off[15];
			raddr = {2'b00, bank[6:0], off[14:0]};
			baddr = {1'b0, bank[3:0], off[14:0]};
		end
		// four 1M windows steered by the bank registers
		if (active && bank >= 8'hc0)
			raddr = {bank_model[bank[5:4]], ca[19:0]};
		e_rom_addr = raddr & rom_mask;
		e_rom_ce_n = !(rom_area && !ram_hit && (rd || wr));
		e_rom_oe_n = !(rom_area && !ram_hit && rd);
		e_bsram_addr = baddr & ram_mask;
		e_bsram_d = cpu_di;
		e_bsram_ce_n = !(ram_hit && (rd || wr));
		e_bsram_oe_n = !(ram_hit && rd);
		e_bsram_we_n = !(ram_hit && wr);
		e_do_known = 1'b1;
		if (reg_sel && rd)
			e_cart_do = {4'h0, bank_model[off[1:0]]};
		else if (!e_rom_oe_n)
			e_cart_do = rom_byte_of(e_rom_addr);
		else if (!e_bsram_oe_n) begin
			e_do_known = bsram_shadow.exists(e_bsram_addr) != 0;
			if (e_do_known)
				e_cart_do = bsram_shadow[e_bsram_addr];
		end else
			e_cart_do = 8'hff;
		if (!e_bsram_we_n)
			bsram_shadow[e_bsram_addr] = cpu_di;
		if (!rst_n)
			bank_model = '{4'd0, 4'd1, 4'd2, 4'd3};
		else if (reg_sel && wr && sysclkf_ce)
			bank_model[off[1:0]] = cpu_di[3:0];
		pend = 1'b1;
	end

	// outputs settle well before the falling edge
	always @(negedge mclk) begin
		if (pend) begin
			compare("rom_ce_n", 24'(e_rom_ce_n), 24'(rom_ce_n));
			compare("rom_oe_n", 24'(e_rom_oe_n), 24'(rom_oe_n));
			compare("bsram_ce_n", 24'(e_bsram_ce_n), 24'(bsram_ce_n));
			compare("bsram_oe_n", 24'(e_bsram_oe_n), 24'(bsram_oe_n));
			compare("bsram_we_n", 24'(e_bsram_we_n), 24'(bsram_we_n));
			if (!e_rom_ce_n)
				compare("rom_addr", e_rom_addr, rom_addr);
			if (!e_bsram_ce_n)
				compare("bsram_addr", 24'(e_bsram_addr), 24'(bsram_addr));
			if (!e_bsram_we_n)
				compare("bsram_d", 24'(e_bsram_d), 24'(bsram_d));
			if (e_do_known)
				compare("cart_do", 24'(e_cart_do), 24'(cart_do));
		end
		if (test_done) begin
			if (test_errors == 0)
				$display("test %s: ok, %0d checks", test_name(test_id), test_checks);
			else
				$display("test %s: %0d of %0d checks wrong", test_name(test_id),
					test_errors, test_checks);
			test_errors = 0;
			test_checks = 0;
		end
	end

	always @(posedge mclk) begin
		cycles <= cycles + 1;
		if (cycles == LIMIT)
			$display("timeout: run still going after %0d cycles", LIMIT);
	end

endmodule

// ==== rtl/cart_map.sv ====
// cartridge memory mapper top
`timescale 1ns/1ns
`include "cart_map_config.svh"

module cart_map
	import cart_map_pkg::*;
(
	input  logic                     mclk,
	input  logic                     rst_n,
	input  logic [`CART_ADDR_W-1:0]  ca,
	input  logic [7:0]               cpu_di,
	input  logic                     cpurd_n,
	input  logic                     cpuwr_n,
	input  logic                     sysclkf_ce,
	input  logic                     sysclkr_ce,
	input  logic [7:0]               map_ctrl,
	input  logic [`ROM_ADDR_W-1:0]   rom_mask,
	input  logic [`BSRAM_ADDR_W-1:0] ram_mask,
	input  logic [15:0]              rom_q,
	input  logic [7:0]               bsram_q,
	output logic [`ROM_ADDR_W-1:0]   rom_addr,
	output logic                     rom_ce_n,
	output logic                     rom_oe_n,
	output logic [`BSRAM_ADDR_W-1:0] bsram_addr,
	output logic [7:0]               bsram_d,
	output logic                     bsram_ce_n,
	output logic                     bsram_oe_n,
	output logic                     bsram_we_n,
	output logic [7:0]               cart_do
);

	rom_req_t   lh_rom_req, sd_rom_req, rom_req;
	bsram_req_t lh_bsram_req, sd_bsram_req, bsram_req;
	logic       reg_hit;
	logic [7:0] reg_do;
	logic       map_active;

	lhrom_map u_lhrom (
		.ca(ca), .cpurd_n(cpurd_n), .cpuwr_n(cpuwr_n), .cpu_di(cpu_di),
		.hirom(map_ctrl[0]), .rom_mask(rom_mask), .ram_mask(ram_mask),
		.rom_req(lh_rom_req), .bsram_req(lh_bsram_req)
	);

	sdd1_map u_sdd1 (
		.mclk(mclk), .rst_n(rst_n), .ca(ca), .cpurd_n(cpurd_n), .cpuwr_n(cpuwr_n),
		.sysclkf_ce(sysclkf_ce), .cpu_di(cpu_di), .map_ctrl(map_ctrl),
		.rom_mask(rom_mask), .ram_mask(ram_mask), .rom_req(sd_rom_req),
		.bsram_req(sd_bsram_req), .reg_hit(reg_hit), .reg_do(reg_do),
		.map_active(map_active)
	);

	map_select #(.payload_t(rom_req_t), .IDLE(ROM_IDLE)) u_rom_sel (
		.mclk(mclk), .rst_n(rst_n), .sysclkr_ce(sysclkr_ce), .map_active(map_active),
		.base_req(lh_rom_req), .chip_req(sd_rom_req), .req(rom_req)
	);

	map_select #(.payload_t(bsram_req_t), .IDLE(BSRAM_IDLE)) u_bsram_sel (
		.mclk(mclk), .rst_n(rst_n), .sysclkr_ce(sysclkr_ce), .map_active(map_active),
		.base_req(lh_bsram_req), .chip_req(sd_bsram_req), .req(bsram_req)
	);

	cpu_read_mux u_read (
		.mclk(mclk), .rst_n(rst_n), .sysclkr_ce(sysclkr_ce), .rom_req(rom_req),
		.bsram_req(bsram_req), .reg_hit(reg_hit), .reg_do(reg_do),
		.rom_q(rom_q), .bsram_q(bsram_q), .cart_do(cart_do)
	);

	assign rom_addr = rom_req.addr;
	assign rom_ce_n = rom_req.ce_n;
	assign rom_oe_n = rom_req.oe_n;
	assign bsram_addr = bsram_req.addr;
	assign bsram_d = bsram_req.d;
	assign bsram_ce_n = bsram_req.ce_n;
	assign bsram_oe_n = bsram_req.oe_n;
	assign bsram_we_n = bsram_req.we_n;

endmodule

// ==== rtl/cpu_read_mux.sv ====
// CPU read data return
`timescale 1ns/1ns
`include "cart_map_config.svh"

module cpu_read_mux
	import cart_map_pkg::*;
(
	input  logic       mclk,
	input  logic       rst_n,
	input  logic       sysclkr_ce,
	input  rom_req_t   rom_req,
	input  bsram_req_t bsram_req,
	input  logic       reg_hit,
	input  logic [7:0] reg_do,
	input  logic [15:0] rom_q,
	input  logic [7:0] bsram_q,
	output logic [7:0] cart_do
);

	logic       reg_hit_q;
	logic [7:0] reg_do_q;
	logic [7:0] rom_byte;

	// line up with the registered requests
	always_ff @(posedge mclk or negedge rst_n) begin
		if (!rst_n)
			reg_hit_q <= 1'b0;
		else if (sysclkr_ce)
			reg_hit_q <= reg_hit;
	end

	always_ff @(posedge mclk) begin
		if (sysclkr_ce)
			reg_do_q <= reg_do;
	end

	// odd addresses sit in the upper byte
	assign rom_byte = rom_req.addr[0] ? rom_q[15:8] : rom_q[7:0];

	always_comb begin
		if (reg_hit_q)
			cart_do = reg_do_q;
		else if (!rom_req.ce_n && !rom_req.oe_n)
			cart_do = rom_byte;
		else if (!bsram_req.ce_n && !bsram_req.oe_n)
			cart_do = bsram_q;
		else
			cart_do = `OPEN_BUS;
	end

	// mappers must never select both chips at once
	a_one_chip: assert property (@(posedge mclk) disable iff (!rst_n)
		rom_req.ce_n || bsram_req.ce_n);

endmodule

// ==== rtl/map_select.sv ====
// registered mapper request select
`timescale 1ns/1ns

module map_select #(
	parameter type payload_t = logic,
	parameter payload_t IDLE = '0
) (
	input  logic     mclk,
	input  logic     rst_n,
	input  logic     sysclkr_ce,
	input  logic     map_active,
	input  payload_t base_req,
	input  payload_t chip_req,
	output payload_t req
);

	// chip mapper wins whenever it claims the cartridge
	always_ff @(posedge mclk or negedge rst_n) begin
		if (!rst_n)
			req <= IDLE;
		else if (sysclkr_ce)
			req <= map_active ? chip_req : base_req;
	end

	// request only moves on a read clock enable
	a_hold_between_ce: assert property (@(posedge mclk) disable iff (!rst_n)
		!sysclkr_ce |=> $stable(req));

endmodule

// ==== rtl/sdd1_map.sv ====
// S-DD1 style bank switched mapper
`timescale 1ns/1ns
`include "cart_map_config.svh"

module sdd1_map
	import cart_map_pkg::*;
(
	input  logic                     mclk,
	input  logic                     rst_n,
	input  logic [`CART_ADDR_W-1:0]  ca,
	input  logic                     cpurd_n,
	input  logic                     cpuwr_n,
	input  logic                     sysclkf_ce,
	input  logic [7:0]               cpu_di,
	input  logic [7:0]               map_ctrl,
	input  logic [`ROM_ADDR_W-1:0]   rom_mask,
	input  logic [`BSRAM_ADDR_W-1:0] ram_mask,
	output rom_req_t                 rom_req,
	output bsram_req_t               bsram_req,
	output logic                     reg_hit,
	output logic [7:0]               reg_do,
	output logic                     map_active
);

	localparam logic [`CART_ADDR_W-1:0] REG_BASE = `SDD1_REG_BASE;

	logic [3:0][3:0] banks;
	logic            reg_sel;
	logic            reg_wr;
	logic            bsram_hit;
	logic            rom_hit;
	logic            access;
	rom_addr_t       rom_addr;

	assign map_active = map_ctrl[7:4] == `SDD1_MAP_ID;

	// 4804-4807 in system banks only
	assign reg_sel = !ca[22] && (ca[15:2] == REG_BASE[15:2]);
	assign reg_wr = map_active && reg_sel && !cpuwr_n && sysclkf_ce;

	always_ff @(posedge mclk or negedge rst_n) begin
		if (!rst_n)
			banks <= `SDD1_RESET_BANKS;
		else if (reg_wr)
			banks[ca[1:0]] <= cpu_di[3:0];
	end

	assign reg_hit = map_active && reg_sel && !cpurd_n;
	assign reg_do = {4'h0, banks[ca[1:0]]};

	// C0-FF is four 1M windows, each pointed at by one bank register
	always_comb begin
		if (ca[23:22] == 2'b11)
			rom_addr = rom_addr_t'({banks[ca[21:20]], ca[19:0]});
		else
			rom_addr = lorom_rom_addr(ca);
	end

	assign bsram_hit = lorom_bsram_hit(ca);
	assign rom_hit = is_rom_area(ca) && !bsram_hit;
	assign access = !cpurd_n || !cpuwr_n;

	assign rom_req.addr = rom_addr & rom_mask;
	assign rom_req.ce_n = !(rom_hit && access);
	assign rom_req.oe_n = !(rom_hit && !cpurd_n);

	assign bsram_req.addr = lorom_bsram_addr(ca) & ram_mask;
	assign bsram_req.d = cpu_di;
	assign bsram_req.ce_n = !(bsram_hit && access);
	assign bsram_req.oe_n = !(bsram_hit && !cpurd_n);
	assign bsram_req.we_n = !(bsram_hit && !cpuwr_n);

	// banks only move on a qualified CPU write
	a_bank_write_only: assert property (@(posedge mclk) disable iff (!rst_n)
		$changed(banks) |-> $past(!cpuwr_n && sysclkf_ce));

endmodule

// ==== rtl/lhrom_map.sv ====
// LoROM and HiROM mapper
`timescale 1ns/1ns
`include "cart_map_config.svh"

module lhrom_map
	import cart_map_pkg::*;
(
	input  logic [`CART_ADDR_W-1:0]  ca,
	input  logic                     cpurd_n,
	input  logic                     cpuwr_n,
	input  logic [7:0]               cpu_di,
	input  logic                     hirom,
	input  logic [`ROM_ADDR_W-1:0]   rom_mask,
	input  logic [`BSRAM_ADDR_W-1:0] ram_mask,
	output rom_req_t                 rom_req,
	output bsram_req_t               bsram_req
);

	logic        bsram_hit;
	logic        rom_hit;
	logic        access;
	rom_addr_t   rom_addr;
	bsram_addr_t bsram_addr;

	always_comb begin
		if (hirom) begin
			// 64K banks straight through
			rom_addr = rom_addr_t'(ca[21:0]);
			// 8K window at 6000-7FFF of banks 20-3F and A0-BF
			bsram_hit = (ca[22:21] == 2'b01) && (ca[15:13] == 3'b011);
			bsram_addr = bsram_addr_t'({ca[20:16], ca[12:0]});
		end else begin
			rom_addr = lorom_rom_addr(ca);
			bsram_hit = lorom_bsram_hit(ca);
			bsram_addr = lorom_bsram_addr(ca);
		end
	end

	// chips only enabled while the CPU strobes
	assign access = !cpurd_n || !cpuwr_n;

	// BSRAM takes precedence inside ROM area
	assign rom_hit = is_rom_area(ca) && !bsram_hit;

	assign rom_req.addr = rom_addr & rom_mask;
	assign rom_req.ce_n = !(rom_hit && access);
	assign rom_req.oe_n = !(rom_hit && !cpurd_n);

	assign bsram_req.addr = bsram_addr & ram_mask;
	assign bsram_req.d = cpu_di;
	assign bsram_req.ce_n = !(bsram_hit && access);
	assign bsram_req.oe_n = !(bsram_hit && !cpurd_n);
	assign bsram_req.we_n = !(bsram_hit && !cpuwr_n);

endmodule

// ==== rtl/cart_map_pkg.sv ====
// cartridge mapper types and decode
`include "cart_map_config.svh"

package cart_map_pkg;

	typedef logic [`ROM_ADDR_W-1:0] rom_addr_t;
	typedef logic [`BSRAM_ADDR_W-1:0] bsram_addr_t;

	typedef struct packed {
		rom_addr_t addr;
		logic      ce_n;
		logic      oe_n;
	} rom_req_t;

	typedef struct packed {
		bsram_addr_t addr;
		logic [7:0]  d;
		logic        ce_n;
		logic        oe_n;
		logic        we_n;
	} bsram_req_t;

	// no access in progress
	localparam rom_req_t ROM_IDLE = '{addr: '0, ce_n: 1'b1, oe_n: 1'b1};
	localparam bsram_req_t BSRAM_IDLE = '{addr: '0, d: '0, ce_n: 1'b1, oe_n: 1'b1, we_n: 1'b1};

	// banks 40-7D and C0-FF whole, upper half of 00-3F and 80-BF
	function automatic logic is_rom_area(input logic [`CART_ADDR_W-1:0] a);
		logic [7:0] bank;
		bank = a[23:16];
		if (bank[6])
			return bank[7:1] != 7'b0111111;
		return a[15];
	endfunction

	// LoROM, 32K pages packed back to back
	function automatic rom_addr_t lorom_rom_addr(input logic [`CART_ADDR_W-1:0] a);
		return rom_addr_t'({a[22:16], a[14:0]});
	endfunction

	// banks 70-7D, lower half
	function automatic logic lorom_bsram_hit(input logic [`CART_ADDR_W-1:0] a);
		return (a[23:20] == 4'h7) && (a[19:17] != 3'b111) && !a[15];
	endfunction

	function automatic bsram_addr_t lorom_bsram_addr(input logic [`CART_ADDR_W-1:0] a);
		return bsram_addr_t'({a[19:16], a[14:0]});
	endfunction

endpackage

// ==== rtl/cart_map_config.svh ====
// cartridge mapper configuration
`ifndef CART_MAP_CONFIG_SVH
`define CART_MAP_CONFIG_SVH

// CPU bus address width
`define CART_ADDR_W 24

// external memory address widths
`define ROM_ADDR_W 24
`define BSRAM_ADDR_W 20

// first S-DD1 bank register, repeated in banks 00-3F and 80-BF
`define SDD1_REG_BASE 24'h004804

// reset bank values, register 3 down to register 0
`define SDD1_RESET_BANKS {4'd3, 4'd2, 4'd1, 4'd0}

// map_ctrl high nibble selecting the S-DD1 mapper
`define SDD1_MAP_ID 4'h5

// value seen by the CPU when no device drives the bus
`define OPEN_BUS 8'hFF

`endif
